//--- feature_buf_pkg.sv
/*
 * Feature output buffer shared definitions.
 * Element, vector and cell command types plus the channel constants.
 */
package feature_buf_pkg;

	// number of channels held in one cell vector.
	localparam int CH = 4;

	// width of one feature element.
	localparam int ELEM_W = 16;

	// width of one x or y coordinate, so a tile is at most 16 by 16 cells.
	localparam int ADDR_W = 4;

	// width of a whole cell vector.
	localparam int VEC_W = CH * ELEM_W;

	// one feature element.
	typedef logic [ELEM_W-1:0] elem_t;

	// one cell's content, element 0 in the low bits.
	typedef elem_t [CH-1:0] vector_t;

	// command broadcast from the decoder to every cell.
	// at most one of load and write is set in any cycle.
	typedef struct packed {
		logic    load;
		logic    write;
		vector_t data;
	} cell_cmd_t;

endpackage

//--- feature_addr_decode.sv
/*
 * Feature buffer address decoder.
 * Turns (x, y) into a one-hot cell select and merges bias preload,
 * write-done preload and accumulate writes into one cell command.
 */
`timescale 1ns/1ps

module feature_addr_decode #(
	parameter int GRID_DIM = 4
) (
	input  logic                                  clk_i,
	input  logic                                  rstn_i,

	input  logic [feature_buf_pkg::ADDR_W-1:0]    addr_x_i,
	input  logic [feature_buf_pkg::ADDR_W-1:0]    addr_y_i,

	input  logic                                  accum_en_i,
	input  logic                                  wr_done_i,
	input  logic                                  bias_full_i,

	input  feature_buf_pkg::vector_t              accum_data_i,
	input  feature_buf_pkg::vector_t              bias_data_i,

	output logic [GRID_DIM*GRID_DIM-1:0]          cell_sel_o,
	output feature_buf_pkg::cell_cmd_t            cell_cmd_o
);

	import feature_buf_pkg::*;

	logic    bias_full_q;
	logic    x_in_range;
	logic    y_in_range;
	logic    load;
	vector_t bias_rev;

	// bias_full is a level from the bias loader; the preload follows one cycle later.
	always_ff @(posedge clk_i)
	begin
		if (!rstn_i)
			bias_full_q <= 1'b0;
		else
			bias_full_q <= bias_full_i;
	end

	// an address at or above GRID_DIM lies off the tile.
	assign x_in_range = (addr_x_i < GRID_DIM);
	assign y_in_range = (addr_y_i < GRID_DIM);

	// cell index is y * GRID_DIM + x.
	// only in-grid coordinates can match, so an off-tile address selects no cell.
	for (genvar gy = 0; gy < GRID_DIM; gy++)
	begin : g_row
		for (genvar gx = 0; gx < GRID_DIM; gx++)
		begin : g_col
			assign cell_sel_o[gy*GRID_DIM+gx] =
				(addr_y_i == ADDR_W'(gy)) && (addr_x_i == ADDR_W'(gx));
		end
	end

	// the bias arrives with its elements in the opposite order to the cells.
	for (genvar gk = 0; gk < CH; gk++)
	begin : g_rev
		assign bias_rev[gk] = bias_data_i[CH-1-gk];
	end

	// a preload of either kind wins over an accumulate in the same cycle.
	assign load = bias_full_q || wr_done_i;

	assign cell_cmd_o.load  = load;
	assign cell_cmd_o.write = accum_en_i && !load;
	assign cell_cmd_o.data  = load ? bias_rev : accum_data_i;

	// an on-tile address selects exactly one cell and an off-tile address selects none.
	a_sel_onehot : assert property (
		@(posedge clk_i) disable iff (!rstn_i)
		(x_in_range && y_in_range) ? $onehot(cell_sel_o) : (cell_sel_o == '0)
	) else $error("feature_addr_decode: cell select does not match the address");

endmodule

//--- feature_cell.sv
/*
 * Feature buffer storage cell.
 * Holds one output vector and applies preload or addressed writes.
 */
`timescale 1ns/1ps

module feature_cell (
	input  logic                          clk_i,
	input  logic                          rstn_i,
	input  logic                          sel_i,
	input  feature_buf_pkg::cell_cmd_t    cmd_i,
	output feature_buf_pkg::vector_t      data_o
);

	// a load reaches every cell, a write only the selected one.
	always_ff @(posedge clk_i)
	begin
		if (!rstn_i)
			data_o <= '0;
		else if (cmd_i.load)
			data_o <= cmd_i.data;
		else if (cmd_i.write && sel_i)
			data_o <= cmd_i.data;
	end

	// the decoder resolves priority, so the cell never sees both.
	a_cmd_exclusive : assert property (
		@(posedge clk_i) disable iff (!rstn_i)
		!(cmd_i.load && cmd_i.write)
	) else $error("feature_cell: load and write set together");

endmodule

//--- feature_out_map.sv
/*
 * Feature buffer output mapper.
 * Reads back the addressed cell and presents all cells as channel planes.
 */
`timescale 1ns/1ps

module feature_out_map #(
	parameter int GRID_DIM = 4
) (
	input  logic [GRID_DIM*GRID_DIM-1:0]    cell_sel_i,
	input  feature_buf_pkg::vector_t        cell_data_i [0:GRID_DIM*GRID_DIM-1],

	output feature_buf_pkg::vector_t        prev_buf_data_o,
	output feature_buf_pkg::elem_t [feature_buf_pkg::CH-1:0][GRID_DIM*GRID_DIM-1:0]
	                                        feature_out_data_o
);

	import feature_buf_pkg::*;

	localparam int NCELL = GRID_DIM * GRID_DIM;

	// and-or read of the addressed cell.
	// with no bit of the select set the result stays zero.
	always_comb
	begin
		vector_t acc;

		acc = '0;
		for (int i = 0; i < NCELL; i++)
		begin
			acc = acc | (cell_data_i[i] & {VEC_W{cell_sel_i[i]}});
		end
		prev_buf_data_o = acc;
	end

	// the DDR write path drains one channel plane at a time,
	// so element c of cell i goes to slot i of plane c.
	for (genvar gc = 0; gc < CH; gc++)
	begin : g_plane
		for (genvar gi = 0; gi < NCELL; gi++)
		begin : g_slot
			assign feature_out_data_o[gc][gi] = cell_data_i[gi][gc];
		end
	end

endmodule

//--- feature_out_reg.sv
/*
 * Feature output register buffer for the convolution accelerator.
 * Holds one CH-element vector per cell of a GRID_DIM by GRID_DIM output tile.
 */
`timescale 1ns/1ps

module feature_out_reg #(
	parameter int GRID_DIM = 4
) (
	input  logic                                  clk_i,
	input  logic                                  rstn_i,

	// accumulate write port, one strobe per write.
	input  logic                                  accum_en_i,
	input  feature_buf_pkg::vector_t              accum_data_i,
	input  logic [feature_buf_pkg::ADDR_W-1:0]    addr_x_i,
	input  logic [feature_buf_pkg::ADDR_W-1:0]    addr_y_i,

	// bias preload.
	input  logic                                  bias_full_i,
	input  feature_buf_pkg::vector_t              bias_data_i,
	input  logic                                  wr_done_i,

	// readback of the addressed cell.
	output feature_buf_pkg::vector_t              prev_buf_data_o,

	// all cells as channel planes for the DDR write path.
	output feature_buf_pkg::elem_t [feature_buf_pkg::CH-1:0][GRID_DIM*GRID_DIM-1:0]
	                                              feature_out_data_o
);

	import feature_buf_pkg::*;

	localparam int NCELL = GRID_DIM * GRID_DIM;

	logic [NCELL-1:0] cell_sel;
	cell_cmd_t        cell_cmd;
	vector_t          cell_data [0:NCELL-1];

	feature_addr_decode #(
		.GRID_DIM     (GRID_DIM)
	) i_feature_addr_decode (
		.clk_i        (clk_i),
		.rstn_i       (rstn_i),
		.addr_x_i     (addr_x_i),
		.addr_y_i     (addr_y_i),
		.accum_en_i   (accum_en_i),
		.wr_done_i    (wr_done_i),
		.bias_full_i  (bias_full_i),
		.accum_data_i (accum_data_i),
		.bias_data_i  (bias_data_i),
		.cell_sel_o   (cell_sel),
		.cell_cmd_o   (cell_cmd)
	);

	// one cell per tile position, indexed y * GRID_DIM + x.
	for (genvar gi = 0; gi < NCELL; gi++)
	begin : g_cell
		feature_cell i_feature_cell (
			.clk_i  (clk_i),
			.rstn_i (rstn_i),
			.sel_i  (cell_sel[gi]),
			.cmd_i  (cell_cmd),
			.data_o (cell_data[gi])
		);
	end

	feature_out_map #(
		.GRID_DIM           (GRID_DIM)
	) i_feature_out_map (
		.cell_sel_i         (cell_sel),
		.cell_data_i        (cell_data),
		.prev_buf_data_o    (prev_buf_data_o),
		.feature_out_data_o (feature_out_data_o)
	);

endmodule

//--- tb_feature_out_reg.sv
/*
 * Testbench for the feature output register buffer.
 * Runs a reference model of the tile next to the DUT and checks both outputs every cycle.
 */
`timescale 1ns/1ps

module tb_feature_out_reg;

	import feature_buf_pkg::*;

	localparam int GRID_DIM = 4;
	localparam int NCELL = GRID_DIM * GRID_DIM;

	typedef elem_t [CH-1:0][NCELL-1:0] planes_t;

	// expected values of both DUT outputs for one address.
	typedef struct packed {
		vector_t prev;
		planes_t planes;
	} expected_t;

	logic              clk;
	logic              rstn;
	logic              accum_en;
	logic              wr_done;
	logic              bias_full;
	vector_t           accum_data;
	vector_t           bias_data;
	logic [ADDR_W-1:0] addr_x;
	logic [ADDR_W-1:0] addr_y;
	vector_t           prev_buf_data;
	planes_t           feature_out_data;

	vector_t model [0:NCELL-1];
	logic    model_bias_q;
	int      seed = 32'h5a42_dacf;
	int      errors = 0;
	int      checks = 0;
	logic    check_en = 1'b0;

	feature_out_reg #(
		.GRID_DIM           (GRID_DIM)
	) i_feature_out_reg (
		.clk_i              (clk),
		.rstn_i             (rstn),
		.accum_en_i         (accum_en),
		.accum_data_i       (accum_data),
		.addr_x_i           (addr_x),
		.addr_y_i           (addr_y),
		.bias_full_i        (bias_full),
		.bias_data_i        (bias_data),
		.wr_done_i          (wr_done),
		.prev_buf_data_o    (prev_buf_data),
		.feature_out_data_o (feature_out_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic vector_t reverse_vec(vector_t v);
		vector_t r;

		for (int k = 0; k < CH; k++)
			r[k] = v[CH-1-k];
		return r;
	endfunction

	function automatic vector_t random_vec();
		return {$random(seed), $random(seed)};
	endfunction

	// expected readback and planes, taken from the reference model.
	function automatic expected_t expected_outputs(logic [ADDR_W-1:0] x, logic [ADDR_W-1:0] y);
		expected_t e;

		e = '0;
		if (x < GRID_DIM && y < GRID_DIM)
			e.prev = model[y*GRID_DIM+x];
		for (int c = 0; c < CH; c++)
			for (int i = 0; i < NCELL; i++)
				e.planes[c][i] = model[i][c];
		return e;
	endfunction

	// reference model, updated on the same edge that the DUT samples.
	always @(posedge clk)
	begin : model_update
		logic load;

		load = model_bias_q || wr_done;
		if (!rstn)
		begin
			for (int i = 0; i < NCELL; i++)
				model[i] = '0;
			model_bias_q = 1'b0;
		end
		else
		begin
			if (load)
			begin
				for (int i = 0; i < NCELL; i++)
					model[i] = reverse_vec(bias_data);
			end
			else if (accum_en && addr_x < GRID_DIM && addr_y < GRID_DIM)
				model[addr_y*GRID_DIM+addr_x] = accum_data;
			model_bias_q = bias_full;
		end
	end

	task automatic check_vec(string name, vector_t exp, vector_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("** Error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic compare_outputs();
		expected_t e;

		e = expected_outputs(addr_x, addr_y);
		check_vec("prev_buf_data_o", e.prev, prev_buf_data);
		for (int c = 0; c < CH; c++)
		begin
			checks++;
			if (feature_out_data[c] !== e.planes[c])
			begin
				errors++;
				$display("** Error at %0d ns: feature_out_data_o[%0d] expected %h, got %h",
					$time, c, e.planes[c], feature_out_data[c]);
			end
		end
	endtask

	// once just after the edge and once late in the cycle, after the address has moved.
	initial
	begin
		forever
		begin
			@(posedge clk);
			#1;
			if (check_en)
				compare_outputs();
			#8;
			if (check_en)
				compare_outputs();
		end
	end

	// inputs change 2 ns after the rising edge.
	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic set_idle();
		accum_en = 1'b0;
		wr_done = 1'b0;
		bias_full = 1'b0;
	endtask

	task automatic finish_test(string name, int err_start);
		$display("test %s done, %0d errors", name, errors - err_start);
	endtask

	task automatic run_tests();
		int err_start;
		int pick;

		// every address up to one past the grid must read zero.
		err_start = errors;
		for (int y = 0; y <= GRID_DIM; y++)
		begin
			for (int x = 0; x <= GRID_DIM; x++)
			begin
				addr_x = x;
				addr_y = y;
				tick();
				check_vec("prev_buf_data_o", '0, prev_buf_data);
			end
		end
		finish_test("reset", err_start);

		err_start = errors;
		addr_x = {$random(seed)} % GRID_DIM;
		addr_y = {$random(seed)} % GRID_DIM;
		bias_data = random_vec();
		wr_done = 1'b1;
		tick();
		wr_done = 1'b0;
		check_vec("prev_buf_data_o", reverse_vec(bias_data), prev_buf_data);
		for (int n = 0; n < 6; n++)
		begin
			addr_x = {$random(seed)} % GRID_DIM;
			addr_y = {$random(seed)} % GRID_DIM;
			tick();
			check_vec("prev_buf_data_o", reverse_vec(bias_data), prev_buf_data);
		end
		finish_test("write-done preload", err_start);

		err_start = errors;
		for (int n = 0; n < 20; n++)
		begin
			addr_x = {$random(seed)} % GRID_DIM;
			addr_y = {$random(seed)} % GRID_DIM;
			accum_data = random_vec();
			accum_en = 1'b1;
			tick();
			check_vec("prev_buf_data_o", accum_data, prev_buf_data);
		end
		set_idle();
		tick();
		finish_test("addressed accumulate", err_start);

		// the preload lands one edge late and beats the accumulate on that edge.
		err_start = errors;
		addr_x = 1;
		addr_y = 2;
		accum_data = random_vec();
		bias_data = random_vec();
		accum_en = 1'b1;
		bias_full = 1'b1;
		tick();
		check_vec("prev_buf_data_o", accum_data, prev_buf_data);
		bias_full = 1'b0;
		addr_x = 3;
		accum_data = random_vec();
		bias_data = random_vec();
		tick();
		check_vec("prev_buf_data_o", reverse_vec(bias_data), prev_buf_data);
		set_idle();
		tick();
		finish_test("delayed bias preload", err_start);

		err_start = errors;
		for (int n = 0; n < 8; n++)
		begin
			pick = GRID_DIM + {$random(seed)} % ((1 << ADDR_W) - GRID_DIM);
			addr_x = (n % 2 == 0) ? pick : {$random(seed)} % GRID_DIM;
			addr_y = (n % 2 == 0) ? {$random(seed)} % (1 << ADDR_W) : pick;
			accum_data = random_vec();
			accum_en = 1'b1;
			tick();
			check_vec("prev_buf_data_o", '0, prev_buf_data);
		end
		set_idle();
		tick();
		finish_test("out-of-range address", err_start);

		err_start = errors;
		for (int n = 0; n < 40; n++)
		begin
			addr_x = {$random(seed)} % (GRID_DIM + 1);
			addr_y = {$random(seed)} % (GRID_DIM + 1);
			accum_data = random_vec();
			bias_data = random_vec();
			accum_en = ({$random(seed)} % 4) != 0;
			wr_done = ({$random(seed)} % 8) == 0;
			bias_full = ({$random(seed)} % 8) == 0;
			tick();
		end
		set_idle();
		tick();
		tick();
		// slot i of plane c must hold element c of cell i.
		for (int i = 0; i < NCELL; i++)
		begin
			addr_x = i % GRID_DIM;
			addr_y = i / GRID_DIM;
			#1;
			for (int c = 0; c < CH; c++)
			begin
				checks++;
				if (feature_out_data[c][i] !== model[i][c])
				begin
					errors++;
					$display("** Error at %0d ns: feature_out_data_o[%0d][%0d] expected %h, got %h",
						$time, c, i, model[i][c], feature_out_data[c][i]);
				end
			end
			check_vec("prev_buf_data_o", model[i], prev_buf_data);
			tick();
		end
		finish_test("plane map", err_start);
	endtask

	initial
	begin : stimulus
		int guard;

		set_idle();
		accum_data = '0;
		bias_data = '0;
		addr_x = '0;
		addr_y = '0;
		rstn = 1'b0;
		repeat (8)
			tick();
		rstn = 1'b1;

		guard = 0;
		while ($isunknown({prev_buf_data, feature_out_data}) && guard < 4)
		begin
			tick();
			guard++;
		end
		if ($isunknown({prev_buf_data, feature_out_data}))
		begin
			$display("timeout: DUT outputs still unknown after reset");
			$display("Regression failed");
			$finish;
		end
		else
		begin
			check_en = 1'b1;
			run_tests();
			$display("checks %0d, errors %0d", checks, errors);
			if (errors == 0)
				$display("Regression passed");
			else
				$display("Regression failed");
			$finish;
		end
	end

endmodule

//--- vlog.f
feature_buf_pkg.sv
feature_addr_decode.sv
feature_cell.sv
feature_out_map.sv
feature_out_reg.sv
tb_feature_out_reg.sv

//--- Bender.yml
package:
  name: feature_out_reg

sources:
  - feature_buf_pkg.sv
  - feature_addr_decode.sv
  - feature_cell.sv
  - feature_out_map.sv
  - feature_out_reg.sv
  - target: test
    files:
      - tb_feature_out_reg.sv
